// File: include/vdp_macros.svh
`ifndef VDP_MACROS_SVH
`define VDP_MACROS_SVH

// datapath and host address widths
`define VDP_DATA_WIDTH 64
`define VDP_ADDR_WIDTH 20

// scratchpad depth in 64-bit words
`define VDP_SPM_ELS 20

// longest operand vector, one lane per element
`define VDP_MAX_LEN 8

// byte address to word index
`define VDP_WORD_SHIFT 3

`endif

// File: design/vdp_pkg.sv
`default_nettype none

`include "vdp_macros.svh"

package vdp_pkg;

  typedef logic [`VDP_DATA_WIDTH-1:0] vdp_word_t;
  typedef logic [`VDP_ADDR_WIDTH-1:0] vdp_addr_t;
  typedef logic [$clog2(`VDP_SPM_ELS)-1:0] vdp_spm_idx_t;

  // holds 0 through VDP_MAX_LEN inclusive
  typedef logic [$clog2(`VDP_MAX_LEN+1)-1:0] vdp_len_t;

  typedef enum logic {
    DEV_CSR = 1'b0,
    DEV_SPM = 1'b1
  } vdp_dev_e;

  // control register map, byte offsets within the csr device
  typedef enum logic [`VDP_ADDR_WIDTH-1:0] {
    CSR_A_PTR   = 20'h00000,
    CSR_B_PTR   = 20'h00040,
    CSR_LEN     = 20'h00080,
    CSR_START   = 20'h000c0,
    CSR_STATUS  = 20'h00100,
    CSR_RES_PTR = 20'h00140
  } vdp_csr_e;

endpackage

`default_nettype wire

// File: design/vdp_csr_io.sv
`timescale 1ns/1ps
`default_nettype none

`include "vdp_macros.svh"

module vdp_csr_io (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   io_cmd_v_i,
  input  logic                   io_cmd_w_i,
  input  vdp_pkg::vdp_dev_e      io_cmd_dev_i,
  input  vdp_pkg::vdp_addr_t     io_cmd_addr_i,
  input  vdp_pkg::vdp_word_t     io_cmd_data_i,
  output logic                   io_resp_v_o,
  output logic                   io_resp_w_o,
  output vdp_pkg::vdp_addr_t     io_resp_addr_o,
  output vdp_pkg::vdp_word_t     io_resp_data_o,
  input  logic                   busy_i,
  input  logic                   done_i,
  input  vdp_pkg::vdp_word_t     spm_rdata_i,
  output logic                   start_o,
  output vdp_pkg::vdp_addr_t     a_ptr_o,
  output vdp_pkg::vdp_addr_t     b_ptr_o,
  output vdp_pkg::vdp_addr_t     res_ptr_o,
  output vdp_pkg::vdp_len_t      len_o,
  output logic                   host_v_o,
  output logic                   host_w_o,
  output vdp_pkg::vdp_spm_idx_t  host_idx_o,
  output vdp_pkg::vdp_word_t     host_wdata_o
);

  import vdp_pkg::*;

  vdp_word_t    a_ptr_r, b_ptr_r, len_r, start_r, res_ptr_r;
  vdp_word_t    csr_rdata, status_w, resp_data_r, host_wdata_r;
  vdp_addr_t    resp_addr_r;
  vdp_spm_idx_t host_idx_r;
  logic         csr_cmd, spm_cmd;
  logic         resp_v_r, resp_w_r, resp_spm_r, rd_pend_r;
  logic         host_v_r, host_w_r;

  assign csr_cmd = io_cmd_v_i & (io_cmd_dev_i == DEV_CSR);
  assign spm_cmd = io_cmd_v_i & (io_cmd_dev_i == DEV_SPM);

  // engine counts as busy from the start write until done
  assign start_o  = |start_r;
  assign status_w = (busy_i | start_o) ? '0 : '1;

  always_comb begin
    csr_rdata = '0;
    case (io_cmd_addr_i)
      CSR_A_PTR:   csr_rdata = a_ptr_r;
      CSR_B_PTR:   csr_rdata = b_ptr_r;
      CSR_LEN:     csr_rdata = len_r;
      CSR_START:   csr_rdata = start_r;
      CSR_STATUS:  csr_rdata = status_w;
      CSR_RES_PTR: csr_rdata = res_ptr_r;
      default:     csr_rdata = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control registers and response timing
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_r    <= '0;
      b_ptr_r    <= '0;
      len_r      <= '0;
      start_r    <= '0;
      res_ptr_r  <= '0;
      resp_v_r   <= 1'b0;
      resp_spm_r <= 1'b0;
      rd_pend_r  <= 1'b0;
      host_v_r   <= 1'b0;
      host_w_r   <= 1'b0;
    end else begin
      // scratchpad read answers a cycle later, once rdata is out of the array
      rd_pend_r  <= spm_cmd & ~io_cmd_w_i;
      resp_spm_r <= rd_pend_r;
      resp_v_r   <= csr_cmd | (spm_cmd & io_cmd_w_i) | rd_pend_r;
      host_v_r   <= spm_cmd;
      host_w_r   <= spm_cmd & io_cmd_w_i;
      if (csr_cmd && io_cmd_w_i) begin
        case (io_cmd_addr_i)
          CSR_A_PTR:   a_ptr_r   <= io_cmd_data_i;
          CSR_B_PTR:   b_ptr_r   <= io_cmd_data_i;
          CSR_LEN:     len_r     <= io_cmd_data_i;
          CSR_START:   start_r   <= io_cmd_data_i;
          CSR_RES_PTR: res_ptr_r <= io_cmd_data_i;
          default: begin
          end
        endcase
      end
      if (done_i) begin
        start_r <= '0;
      end
    end
  end

  // echoed fields and host payload
  always_ff @(posedge clk_i) begin
    if (io_cmd_v_i) begin
      resp_w_r     <= io_cmd_w_i;
      resp_addr_r  <= io_cmd_addr_i;
      resp_data_r  <= (csr_cmd && !io_cmd_w_i) ? csr_rdata : '0;
      host_idx_r   <= vdp_spm_idx_t'(io_cmd_addr_i >> `VDP_WORD_SHIFT);
      host_wdata_r <= io_cmd_data_i;
    end
  end

  assign io_resp_v_o    = resp_v_r;
  assign io_resp_w_o    = resp_w_r;
  assign io_resp_addr_o = resp_addr_r;
  assign io_resp_data_o = resp_spm_r ? spm_rdata_i : resp_data_r;

  assign host_v_o     = host_v_r;
  assign host_w_o     = host_w_r;
  assign host_idx_o   = host_idx_r;
  assign host_wdata_o = host_wdata_r;

  assign a_ptr_o   = a_ptr_r[`VDP_ADDR_WIDTH-1:0];
  assign b_ptr_o   = b_ptr_r[`VDP_ADDR_WIDTH-1:0];
  assign res_ptr_o = res_ptr_r[`VDP_ADDR_WIDTH-1:0];
  // saturate so the engine never walks past its lanes
  assign len_o = (len_r > `VDP_MAX_LEN) ? vdp_len_t'(`VDP_MAX_LEN) : vdp_len_t'(len_r);

endmodule

`default_nettype wire

// File: design/vdp_fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "vdp_macros.svh"

module vdp_fetch_ctrl (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  start_i,
  input  vdp_pkg::vdp_addr_t                    a_ptr_i,
  input  vdp_pkg::vdp_addr_t                    b_ptr_i,
  input  vdp_pkg::vdp_addr_t                    res_ptr_i,
  input  vdp_pkg::vdp_len_t                     len_i,
  input  vdp_pkg::vdp_word_t                    spm_rdata_i,
  input  vdp_pkg::vdp_word_t                    dot_i,
  output logic                                  busy_o,
  output logic                                  done_o,
  output logic                                  eng_v_o,
  output logic                                  eng_w_o,
  output vdp_pkg::vdp_spm_idx_t                 eng_idx_o,
  output vdp_pkg::vdp_word_t                    eng_wdata_o,
  output logic                                  clear_o,
  output logic                                  load_v_o,
  output logic                                  load_b_o,
  output logic [$clog2(`VDP_MAX_LEN)-1:0]       load_idx_o,
  output vdp_pkg::vdp_word_t                    load_data_o
);

  import vdp_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_CAP_A,
    ST_SWITCH_B,
    ST_CAP_B,
    ST_WB,
    ST_DONE
  } state_e;

  state_e                           state_r, state_n;
  logic [$clog2(`VDP_MAX_LEN)-1:0]  cnt_r;
  logic                             b_sel_r;
  logic                             last_el;
  vdp_addr_t                        rd_ptr;

  assign last_el = (vdp_len_t'(cnt_r) == (len_i - vdp_len_t'(1)));

  always_comb begin
    state_n = state_r;
    case (state_r)
      // zero length skips straight to writing the cleared sum
      ST_IDLE:     if (start_i) state_n = (len_i == '0) ? ST_WB : ST_FETCH;
      ST_FETCH:    state_n = b_sel_r ? ST_CAP_B : ST_CAP_A;
      ST_CAP_A:    state_n = last_el ? ST_SWITCH_B : ST_FETCH;
      ST_SWITCH_B: state_n = ST_FETCH;
      ST_CAP_B:    state_n = last_el ? ST_WB : ST_FETCH;
      ST_WB:       state_n = ST_DONE;
      ST_DONE:     state_n = ST_IDLE;
      default:     state_n = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ST_IDLE;
      cnt_r   <= '0;
      b_sel_r <= 1'b0;
    end else begin
      state_r <= state_n;
      case (state_r)
        ST_IDLE: begin
          cnt_r   <= '0;
          b_sel_r <= 1'b0;
        end
        ST_CAP_A: cnt_r <= last_el ? '0 : cnt_r + 1'b1;
        ST_SWITCH_B: b_sel_r <= 1'b1;
        ST_CAP_B: if (!last_el) cnt_r <= cnt_r + 1'b1;
        default: begin
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // scratchpad requests
  assign rd_ptr      = b_sel_r ? b_ptr_i : a_ptr_i;
  assign eng_v_o     = (state_r == ST_FETCH) | (state_r == ST_WB);
  assign eng_w_o     = (state_r == ST_WB);
  assign eng_idx_o   = eng_w_o ? vdp_spm_idx_t'(res_ptr_i >> `VDP_WORD_SHIFT)
                               : vdp_spm_idx_t'(rd_ptr >> `VDP_WORD_SHIFT)
                                 + vdp_spm_idx_t'(cnt_r);
  assign eng_wdata_o = dot_i;

  // dot unit steering, rdata is valid in the capture states
  assign clear_o     = (state_r == ST_IDLE) & start_i;
  assign load_v_o    = (state_r == ST_CAP_A) | (state_r == ST_CAP_B);
  assign load_b_o    = b_sel_r;
  assign load_idx_o  = cnt_r;
  assign load_data_o = spm_rdata_i;

  assign busy_o = (state_r != ST_IDLE);
  assign done_o = (state_r == ST_DONE);

endmodule

`default_nettype wire

// File: design/vdp_dot_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "vdp_macros.svh"

module vdp_dot_unit (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             clear_i,
  input  logic                             load_v_i,
  input  logic                             load_b_i,
  input  logic [$clog2(`VDP_MAX_LEN)-1:0]  load_idx_i,
  input  vdp_pkg::vdp_word_t               load_data_i,
  output vdp_pkg::vdp_word_t               dot_o
);

  import vdp_pkg::*;

  vdp_word_t op_a_r [`VDP_MAX_LEN];
  vdp_word_t op_b_r [`VDP_MAX_LEN];
  vdp_word_t prod   [`VDP_MAX_LEN];
  vdp_word_t sum_l1 [4];
  vdp_word_t sum_l2 [2];

  // unloaded lanes stay zero and add nothing
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      for (int i = 0; i < `VDP_MAX_LEN; i++) begin
        op_a_r[i] <= '0;
        op_b_r[i] <= '0;
      end
    end else if (load_v_i) begin
      if (load_b_i) begin
        op_b_r[load_idx_i] <= load_data_i;
      end else begin
        op_a_r[load_idx_i] <= load_data_i;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // products truncate to 64 bits, then a 4-2-1 tree
  for (genvar i = 0; i < `VDP_MAX_LEN; i++) begin : g_mul
    assign prod[i] = op_a_r[i] * op_b_r[i];
  end

  for (genvar i = 0; i < 4; i++) begin : g_l1
    assign sum_l1[i] = prod[2*i] + prod[2*i+1];
  end

  for (genvar i = 0; i < 2; i++) begin : g_l2
    assign sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
  end

  assign dot_o = sum_l2[0] + sum_l2[1];

endmodule

`default_nettype wire

// File: design/vdp_spm.sv
`timescale 1ns/1ps
`default_nettype none

`include "vdp_macros.svh"

module vdp_spm (
  input  logic                   clk_i,
  input  logic                   host_v_i,
  input  logic                   host_w_i,
  input  vdp_pkg::vdp_spm_idx_t  host_idx_i,
  input  vdp_pkg::vdp_word_t     host_wdata_i,
  input  logic                   eng_v_i,
  input  logic                   eng_w_i,
  input  vdp_pkg::vdp_spm_idx_t  eng_idx_i,
  input  vdp_pkg::vdp_word_t     eng_wdata_i,
  output vdp_pkg::vdp_word_t     rdata_o
);

  import vdp_pkg::*;

  vdp_word_t    mem_r [`VDP_SPM_ELS];
  logic         v, w;
  vdp_spm_idx_t idx;
  vdp_word_t    wdata;

  // single port, host takes it when both ask
  assign v     = host_v_i | eng_v_i;
  assign w     = host_v_i ? host_w_i : eng_w_i;
  assign idx   = host_v_i ? host_idx_i : eng_idx_i;
  assign wdata = host_v_i ? host_wdata_i : eng_wdata_i;

  // indices past the last word are dropped
  always_ff @(posedge clk_i) begin
    if (v && (idx < `VDP_SPM_ELS)) begin
      if (w) begin
        mem_r[idx] <= wdata;
      end else begin
        rdata_o <= mem_r[idx];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/vdp_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vdp_macros.svh"

module vdp_accel_top (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                io_cmd_v_i,
  input  logic                io_cmd_w_i,
  input  vdp_pkg::vdp_dev_e   io_cmd_dev_i,
  input  vdp_pkg::vdp_addr_t  io_cmd_addr_i,
  input  vdp_pkg::vdp_word_t  io_cmd_data_i,
  output logic                io_resp_v_o,
  output logic                io_resp_w_o,
  output vdp_pkg::vdp_addr_t  io_resp_addr_o,
  output vdp_pkg::vdp_word_t  io_resp_data_o
);

  import vdp_pkg::*;

  // csr block to engine
  logic      start, busy, done;
  vdp_addr_t a_ptr, b_ptr, res_ptr;
  vdp_len_t  len;

  // scratchpad ports
  logic         host_v, host_w, eng_v, eng_w;
  vdp_spm_idx_t host_idx, eng_idx;
  vdp_word_t    host_wdata, eng_wdata, spm_rdata;

  // engine to dot unit
  logic                                clear, load_v, load_b;
  logic [$clog2(`VDP_MAX_LEN)-1:0]     load_idx;
  vdp_word_t                           load_data, dot;

  vdp_csr_io i_csr_io (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .io_cmd_v_i     (io_cmd_v_i),
    .io_cmd_w_i     (io_cmd_w_i),
    .io_cmd_dev_i   (io_cmd_dev_i),
    .io_cmd_addr_i  (io_cmd_addr_i),
    .io_cmd_data_i  (io_cmd_data_i),
    .io_resp_v_o    (io_resp_v_o),
    .io_resp_w_o    (io_resp_w_o),
    .io_resp_addr_o (io_resp_addr_o),
    .io_resp_data_o (io_resp_data_o),
    .busy_i         (busy),
    .done_i         (done),
    .spm_rdata_i    (spm_rdata),
    .start_o        (start),
    .a_ptr_o        (a_ptr),
    .b_ptr_o        (b_ptr),
    .res_ptr_o      (res_ptr),
    .len_o          (len),
    .host_v_o       (host_v),
    .host_w_o       (host_w),
    .host_idx_o     (host_idx),
    .host_wdata_o   (host_wdata)
  );

  vdp_fetch_ctrl i_fetch_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (start),
    .a_ptr_i     (a_ptr),
    .b_ptr_i     (b_ptr),
    .res_ptr_i   (res_ptr),
    .len_i       (len),
    .spm_rdata_i (spm_rdata),
    .dot_i       (dot),
    .busy_o      (busy),
    .done_o      (done),
    .eng_v_o     (eng_v),
    .eng_w_o     (eng_w),
    .eng_idx_o   (eng_idx),
    .eng_wdata_o (eng_wdata),
    .clear_o     (clear),
    .load_v_o    (load_v),
    .load_b_o    (load_b),
    .load_idx_o  (load_idx),
    .load_data_o (load_data)
  );

  vdp_dot_unit i_dot_unit (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .clear_i     (clear),
    .load_v_i    (load_v),
    .load_b_i    (load_b),
    .load_idx_i  (load_idx),
    .load_data_i (load_data),
    .dot_o       (dot)
  );

  vdp_spm i_spm (
    .clk_i        (clk_i),
    .host_v_i     (host_v),
    .host_w_i     (host_w),
    .host_idx_i   (host_idx),
    .host_wdata_i (host_wdata),
    .eng_v_i      (eng_v),
    .eng_w_i      (eng_w),
    .eng_idx_i    (eng_idx),
    .eng_wdata_i  (eng_wdata),
    .rdata_o      (spm_rdata)
  );

endmodule

`default_nettype wire

// File: bench/vdp_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 8 ns period
  localparam int half_period_ns = 4;
  localparam int reset_cycles   = 2;

  initial begin
    clk_o = 1'b0;
    forever #(half_period_ns) clk_o = ~clk_o;
  end

  // released on a rising edge, like any other synchronous input
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: bench/vdp_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vdp_macros.svh"

module vdp_tb;

  import vdp_pkg::*;

  // all tests take roughly 400 cycles, the limit leaves a wide margin
  localparam int timeout_cycles = 4000;
  localparam int max_polls      = 100;

  // scratchpad layout, word indices
  localparam int a_idx = 0;
  localparam int b_idx = 8;

  localparam vdp_word_t all_ones = '1;
  localparam int spm_idx_list [5] = '{0, 3, 7, 12, 19};

  logic      clk, reset;
  logic      cmd_v, cmd_w;
  vdp_dev_e  cmd_dev;
  vdp_addr_t cmd_addr;
  vdp_word_t cmd_data;
  logic      resp_v, resp_w;
  vdp_addr_t resp_addr;
  vdp_word_t resp_data;

  int        cycles = 0;
  int        checks = 0;
  int        errors = 0;
  int        tests  = 0;
  integer    seed   = 32'hda73_7bf0;
  vdp_word_t vec_a [`VDP_MAX_LEN];
  vdp_word_t vec_b [`VDP_MAX_LEN];

  vdp_clock_gen i_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  vdp_accel_top i_vdp_accel_top (
    .clk_i          (clk),
    .reset_i        (reset),
    .io_cmd_v_i     (cmd_v),
    .io_cmd_w_i     (cmd_w),
    .io_cmd_dev_i   (cmd_dev),
    .io_cmd_addr_i  (cmd_addr),
    .io_cmd_data_i  (cmd_data),
    .io_resp_v_o    (resp_v),
    .io_resp_w_o    (resp_w),
    .io_resp_addr_o (resp_addr),
    .io_resp_data_o (resp_data)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks

  task automatic check_word(input string what, input vdp_word_t got, input vdp_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input string what, input logic got_w, input vdp_addr_t got_addr,
                            input logic exp_w, input vdp_addr_t exp_addr);
    checks++;
    if (got_w !== exp_w || got_addr !== exp_addr) begin
      errors++;
      $display("CHECK FAILED at %0t: %s echo w=%b addr=%h expected w=%b addr=%h",
               $time, what, got_w, got_addr, exp_w, exp_addr);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host side

  task automatic host_access(input logic w, input vdp_dev_e dev, input vdp_addr_t addr,
                             input vdp_word_t data, output vdp_word_t rdata);
    string what;
    int    lat;
    int    exp_lat;
    what    = $sformatf("%s %s 0x%h", dev.name(), w ? "write" : "read", addr);
    exp_lat = (dev == DEV_SPM && !w) ? 2 : 1;
    lat     = 0;
    @(posedge clk);
    cmd_v    <= 1'b1;
    cmd_w    <= w;
    cmd_dev  <= dev;
    cmd_addr <= addr;
    cmd_data <= data;
    @(posedge clk);
    cmd_v <= 1'b0;
    while (!resp_v) begin
      @(posedge clk);
      lat++;
    end
    checks++;
    if (lat != exp_lat) begin
      errors++;
      $display("CHECK FAILED at %0t: %s latency %0d expected %0d", $time, what, lat, exp_lat);
    end
    check_resp(what, resp_w, resp_addr, w, addr);
    rdata = resp_data;
  endtask

  task automatic csr_write(input vdp_addr_t addr, input vdp_word_t data);
    vdp_word_t rd;
    host_access(1'b1, DEV_CSR, addr, data, rd);
    check_word("csr write response data", rd, '0);
  endtask

  task automatic csr_read(input vdp_addr_t addr, output vdp_word_t data);
    host_access(1'b0, DEV_CSR, addr, '0, data);
  endtask

  task automatic spm_write(input int idx, input vdp_word_t data);
    vdp_word_t rd;
    host_access(1'b1, DEV_SPM, vdp_addr_t'(idx * 8), data, rd);
    check_word("spm write response data", rd, '0);
  endtask

  task automatic spm_read(input int idx, output vdp_word_t data);
    host_access(1'b0, DEV_SPM, vdp_addr_t'(idx * 8), '0, data);
  endtask

  task automatic rand_word(output vdp_word_t w);
    w = {$random(seed), $random(seed)};
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("test %s done, %0d errors", name, errors - err_before);
  endtask

  task automatic reg_roundtrip(input string name, input vdp_addr_t addr, input vdp_word_t value);
    vdp_word_t rd;
    csr_write(addr, value);
    csr_read(addr, rd);
    check_word({name, " readback"}, rd, value);
  endtask

  // starts the engine on the vectors at a_idx and b_idx, checks the stored sum
  task automatic run_dot(input int len, input int res_idx);
    vdp_word_t rd;
    vdp_word_t exp;
    vdp_word_t start_val;
    int        polls;
    exp = '0;
    for (int i = 0; i < len; i++) begin
      exp += vec_a[i] * vec_b[i];
    end
    rand_word(start_val);
    start_val = start_val | vdp_word_t'(1);
    csr_write(CSR_A_PTR, vdp_word_t'(a_idx * 8));
    csr_write(CSR_B_PTR, vdp_word_t'(b_idx * 8));
    csr_write(CSR_RES_PTR, vdp_word_t'(res_idx * 8));
    csr_write(CSR_LEN, vdp_word_t'(len));
    csr_write(CSR_START, start_val);
    // start holds its written value until the run ends
    csr_read(CSR_START, rd);
    check_word("start while running", rd, start_val);
    polls = 0;
    rd    = '0;
    while (rd !== all_ones && polls < max_polls) begin
      csr_read(CSR_STATUS, rd);
      polls++;
    end
    if (rd !== all_ones) begin
      errors++;
      $display("engine still busy after %0d status polls (len %0d)", polls, len);
    end else begin
      if (polls < 2) begin
        errors++;
        $display("engine never reported busy after start (len %0d)", len);
      end
      spm_read(res_idx, rd);
      check_word($sformatf("dot product len %0d", len), rd, exp);
      csr_read(CSR_START, rd);
      check_word("start after done", rd, '0);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests

  task automatic test_reset_values();
    int        err0;
    vdp_word_t rd;
    err0 = errors;
    csr_read(CSR_STATUS, rd);
    check_word("status after reset", rd, all_ones);
    csr_read(CSR_A_PTR, rd);
    check_word("a_ptr after reset", rd, '0);
    csr_read(CSR_B_PTR, rd);
    check_word("b_ptr after reset", rd, '0);
    csr_read(CSR_LEN, rd);
    check_word("len after reset", rd, '0);
    csr_read(CSR_START, rd);
    check_word("start after reset", rd, '0);
    csr_read(CSR_RES_PTR, rd);
    check_word("res_ptr after reset", rd, '0);
    report_test("reset_values", err0);
  endtask

  // start is covered by run_dot, where a nonzero value can launch the engine
  task automatic test_reg_access();
    int        err0;
    vdp_word_t val;
    vdp_word_t rd;
    err0 = errors;
    rand_word(val);
    reg_roundtrip("a_ptr", CSR_A_PTR, val);
    rand_word(val);
    reg_roundtrip("b_ptr", CSR_B_PTR, val);
    rand_word(val);
    reg_roundtrip("len", CSR_LEN, val);
    rand_word(val);
    reg_roundtrip("res_ptr", CSR_RES_PTR, val);
    // status is read only
    csr_write(CSR_STATUS, '0);
    csr_read(CSR_STATUS, rd);
    check_word("status after write", rd, all_ones);
    csr_read(20'h00180, rd);
    check_word("unmapped 0x180", rd, '0);
    csr_read(20'h00008, rd);
    check_word("unmapped 0x008", rd, '0);
    report_test("reg_access", err0);
  endtask

  task automatic test_spm_access();
    int        err0;
    vdp_word_t vals [5];
    vdp_word_t rd;
    err0 = errors;
    for (int i = 0; i < 5; i++) begin
      rand_word(vals[i]);
      spm_write(spm_idx_list[i], vals[i]);
    end
    for (int i = 0; i < 5; i++) begin
      spm_read(spm_idx_list[i], rd);
      check_word($sformatf("spm word %0d", spm_idx_list[i]), rd, vals[i]);
    end
    report_test("spm_access", err0);
  endtask

  task automatic test_full_dot();
    int err0;
    err0 = errors;
    for (int i = 0; i < `VDP_MAX_LEN; i++) begin
      rand_word(vec_a[i]);
      rand_word(vec_b[i]);
      spm_write(a_idx + i, vec_a[i]);
      spm_write(b_idx + i, vec_b[i]);
    end
    run_dot(`VDP_MAX_LEN, 16);
    report_test("full_dot", err0);
  endtask

  // same operands as the full run, so stale lanes would change the sum
  task automatic test_short_dot();
    int err0;
    err0 = errors;
    run_dot(5, 17);
    run_dot(1, 18);
    report_test("short_dot", err0);
  endtask

  initial begin
    cmd_v    = 1'b0;
    cmd_w    = 1'b0;
    cmd_dev  = DEV_CSR;
    cmd_addr = '0;
    cmd_data = '0;
    @(posedge clk);
    while (reset) begin
      @(posedge clk);
    end
    test_reset_values();
    test_reg_access();
    test_spm_access();
    test_full_dot();
    test_short_dot();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
design/vdp_pkg.sv
design/vdp_csr_io.sv
design/vdp_fetch_ctrl.sv
design/vdp_dot_unit.sv
design/vdp_spm.sv
design/vdp_accel_top.sv
bench/vdp_clock_gen.sv
bench/vdp_tb.sv

// File: Makefile
# Verilator build and run of the dot-product accelerator testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module vdp_tb \
	  -Mdir obj_dir -o vdp_tb

run: compile
	./obj_dir/vdp_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
